// ==== cfu_defs.svh ====
`ifndef CFU_DEFS_SVH
`define CFU_DEFS_SVH

// Buffer address widths
`define CFU_A_ADDR_BITS 8
`define CFU_B_ADDR_BITS 8
`define CFU_C_ADDR_BITS 2

// Datapath sizes
`define CFU_ELEM_BITS   8
`define CFU_ACC_BITS    32
`define CFU_LANES       4

// Command fields, K up to 256
`define CFU_FUNCT7_BITS 7
`define CFU_K_BITS      9

`endif

// ==== cfu_pkg.sv ====
`include "cfu_defs.svh"

package cfu_pkg;

  // Opcode lives in function id bits 9:3
  typedef enum logic [`CFU_FUNCT7_BITS-1:0] {
    OP_WRITE_A = 0,
    OP_WRITE_B = 1,
    OP_COMPUTE = 2,
    OP_READ_C  = 3
  } cfu_op_e;

  typedef enum logic [2:0] {
    CTRL_IDLE, CTRL_ACCESS, CTRL_READ_WAIT, CTRL_CALC, CTRL_RESPOND
  } ctrl_state_e;

  typedef enum logic [2:0] {
    ENG_IDLE, ENG_LOAD, ENG_DRAIN, ENG_WRITEBACK, ENG_DONE
  } eng_state_e;

  typedef logic signed [`CFU_ELEM_BITS-1:0] elem_t;
  typedef logic signed [`CFU_ACC_BITS-1:0]  acc_t;

  // Lane 0 sits in the top bits
  typedef logic [`CFU_LANES*`CFU_ACC_BITS-1:0] row_t;

  typedef struct packed {
    logic                        we;
    logic [`CFU_A_ADDR_BITS-1:0] addr;
    logic [`CFU_ELEM_BITS-1:0]   data;
  } buf_a_req_t;

  typedef struct packed {
    logic                                we;
    logic [`CFU_B_ADDR_BITS-1:0]         addr;
    logic [`CFU_LANES*`CFU_ELEM_BITS-1:0] data;
  } buf_b_req_t;

  typedef struct packed {
    logic                        we;
    logic [`CFU_C_ADDR_BITS-1:0] addr;
    row_t                        data;
  } buf_c_req_t;

endpackage

// ==== cfu_buffer.sv ====
`timescale 1ns/1ps

module cfu_buffer #(
  parameter int DATA_BITS = 8,
  parameter int ADDR_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 we,
  input  logic [ADDR_BITS-1:0] addr,
  input  logic [DATA_BITS-1:0] wdata,
  output logic [DATA_BITS-1:0] rdata
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  logic [DATA_BITS-1:0] mem [DEPTH];

  // Write has priority, otherwise the addressed entry is registered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else if (we) begin
      mem[addr] <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

// ==== buffer_arbiter.sv ====
`timescale 1ns/1ps

module buffer_arbiter import cfu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       eng_grant,
  input  buf_a_req_t ctrl_a,
  input  buf_b_req_t ctrl_b,
  input  buf_c_req_t ctrl_c,
  input  buf_a_req_t eng_a,
  input  buf_b_req_t eng_b,
  input  buf_c_req_t eng_c,
  output buf_a_req_t buf_a,
  output buf_b_req_t buf_b,
  output buf_c_req_t buf_c
);

  logic any_we;

  // Engine owns all three ports for the whole handshake
  assign buf_a = eng_grant ? eng_a : ctrl_a;
  assign buf_b = eng_grant ? eng_b : ctrl_b;
  assign buf_c = eng_grant ? eng_c : ctrl_c;

  assign any_we = buf_a.we || buf_b.we || buf_c.we;

  // Host writes must never collide with a run
  a_no_ctrl_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    eng_grant |-> !(ctrl_a.we || ctrl_b.we || ctrl_c.we)
  );

  // Ownership only changes between writes
  a_grant_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    any_we |=> $stable(eng_grant)
  );

endmodule

// ==== cfu_cmd_ctrl.sv ====
`timescale 1ns/1ps
`include "cfu_defs.svh"

module cfu_cmd_ctrl import cfu_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_valid,
  output logic                         cmd_ready,
  input  logic [`CFU_FUNCT7_BITS+2:0]  cmd_function_id,
  input  logic [31:0]                  cmd_inputs_0,
  input  logic [31:0]                  cmd_inputs_1,
  output logic                         rsp_valid,
  input  logic                         rsp_ready,
  output logic [31:0]                  rsp_output,
  output logic                         calc_req,
  input  logic                         calc_ack,
  output logic [`CFU_K_BITS-1:0]       k_len,
  output logic                         eng_grant,
  output buf_a_req_t                   ctrl_a,
  output buf_b_req_t                   ctrl_b,
  output buf_c_req_t                   ctrl_c,
  input  row_t                         c_rdata
);

  ctrl_state_e state;
  cfu_op_e     op_dec;
  cfu_op_e     op_q;
  logic [31:0] in0_q;
  logic [31:0] in1_q;
  logic        cmd_accept;
  acc_t        col_sel;

  assign cmd_ready  = (state == CTRL_IDLE) && !rsp_valid;
  assign cmd_accept = cmd_valid && cmd_ready;
  assign op_dec     = cfu_op_e'(cmd_function_id[`CFU_FUNCT7_BITS+2:3]);

  // Operands of the command in flight
  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      op_q  <= op_dec;
      in0_q <= cmd_inputs_0;
      in1_q <= cmd_inputs_1;
    end
  end

  // Column 0 is the top word of the row
  assign col_sel = c_rdata[(`CFU_LANES-1-in1_q[1:0])*`CFU_ACC_BITS +: `CFU_ACC_BITS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= CTRL_IDLE;
      rsp_valid  <= 1'b0;
      rsp_output <= '0;
      calc_req   <= 1'b0;
    end else begin
      case (state)
        CTRL_IDLE: begin
          if (cmd_accept) begin
            case (op_dec)
              OP_WRITE_A, OP_WRITE_B, OP_READ_C: state <= CTRL_ACCESS;
              OP_COMPUTE: begin
                state    <= CTRL_CALC;
                calc_req <= 1'b1;
              end
              default: begin
                state      <= CTRL_RESPOND;
                rsp_valid  <= 1'b1;
                rsp_output <= '0;
              end
            endcase
          end
        end
        CTRL_ACCESS: begin
          if (op_q == OP_READ_C) begin
            state <= CTRL_READ_WAIT;
          end else begin
            state      <= CTRL_RESPOND;
            rsp_valid  <= 1'b1;
            rsp_output <= '0;
          end
        end
        CTRL_READ_WAIT: begin
          state      <= CTRL_RESPOND;
          rsp_valid  <= 1'b1;
          rsp_output <= col_sel;
        end
        CTRL_CALC: begin
          // Drop req on ack, respond once ack has fallen
          if (calc_req && calc_ack) begin
            calc_req <= 1'b0;
          end else if (!calc_req && !calc_ack) begin
            state      <= CTRL_RESPOND;
            rsp_valid  <= 1'b1;
            rsp_output <= '0;
          end
        end
        CTRL_RESPOND: begin
          if (rsp_ready) begin
            state     <= CTRL_IDLE;
            rsp_valid <= 1'b0;
          end
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

  assign k_len     = in0_q[`CFU_K_BITS-1:0];
  assign eng_grant = calc_req || calc_ack;

  assign ctrl_a = '{we:   (state == CTRL_ACCESS) && (op_q == OP_WRITE_A),
                    addr: in0_q[`CFU_A_ADDR_BITS-1:0],
                    data: in1_q[31:24]};
  assign ctrl_b = '{we:   (state == CTRL_ACCESS) && (op_q == OP_WRITE_B),
                    addr: in0_q[`CFU_B_ADDR_BITS-1:0],
                    data: in1_q};
  assign ctrl_c = '{we: 1'b0, addr: in0_q[`CFU_C_ADDR_BITS-1:0], data: '0};

  a_req_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    calc_req && !calc_ack |=> calc_req
  );

endmodule

// ==== systolic_row.sv ====
`timescale 1ns/1ps
`include "cfu_defs.svh"

module systolic_row import cfu_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 clear,
  input  logic                                 in_valid,
  input  elem_t                                a_in,
  input  logic [`CFU_LANES*`CFU_ELEM_BITS-1:0] b_in,
  output row_t                                 acc_row
);

  // Operands seen by each element
  elem_t                 a_pe [`CFU_LANES];
  elem_t                 b_pe [`CFU_LANES];
  logic [`CFU_LANES-1:0] v_pe;

  // East-moving A and its valid flag
  elem_t                 a_q [1:`CFU_LANES-1];
  logic [`CFU_LANES-1:1] v_q;

  always_ff @(posedge clk) begin
    a_q[1] <= a_in;
    for (int j = 2; j < `CFU_LANES; j++) begin
      a_q[j] <= a_q[j-1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v_q <= '0;
    end else begin
      v_q <= {v_q[`CFU_LANES-2:1], in_valid};
    end
  end

  for (genvar j = 0; j < `CFU_LANES; j++) begin : g_lane
    elem_t b_byte;
    acc_t  acc;

    assign b_byte = b_in[(`CFU_LANES-1-j)*`CFU_ELEM_BITS +: `CFU_ELEM_BITS];

    if (j == 0) begin : g_west
      assign a_pe[j] = a_in;
      assign b_pe[j] = b_byte;
      assign v_pe[j] = in_valid;
    end else begin : g_skew
      // Lane j waits j cycles to meet its A element
      elem_t b_sr [j];

      always_ff @(posedge clk) begin
        b_sr[0] <= b_byte;
        for (int d = 1; d < j; d++) begin
          b_sr[d] <= b_sr[d-1];
        end
      end

      assign a_pe[j] = a_q[j];
      assign b_pe[j] = b_sr[j-1];
      assign v_pe[j] = v_q[j];
    end

    // Signed MAC
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        acc <= '0;
      end else if (clear) begin
        acc <= '0;
      end else if (v_pe[j]) begin
        acc <= acc + a_pe[j] * b_pe[j];
      end
    end

    assign acc_row[(`CFU_LANES-1-j)*`CFU_ACC_BITS +: `CFU_ACC_BITS] = acc;
  end

endmodule

// ==== matmul_engine.sv ====
`timescale 1ns/1ps
`include "cfu_defs.svh"

module matmul_engine import cfu_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 calc_req,
  input  logic [`CFU_K_BITS-1:0]               k_len,
  output logic                                 calc_ack,
  output logic                                 row_clear,
  output logic                                 row_valid,
  output elem_t                                row_a,
  output logic [`CFU_LANES*`CFU_ELEM_BITS-1:0] row_b,
  input  elem_t                                a_rdata,
  input  logic [`CFU_LANES*`CFU_ELEM_BITS-1:0] b_rdata,
  input  row_t                                 acc_row,
  output buf_a_req_t                           eng_a,
  output buf_b_req_t                           eng_b,
  output buf_c_req_t                           eng_c
);

  eng_state_e             state;
  logic [`CFU_K_BITS-1:0] cnt;
  logic                   issue;
  logic                   issue_q;

  assign issue     = (state == ENG_LOAD) && (cnt < k_len);
  assign row_clear = (state == ENG_IDLE) && calc_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ENG_IDLE;
      cnt      <= '0;
      issue_q  <= 1'b0;
      calc_ack <= 1'b0;
    end else begin
      issue_q <= issue;
      case (state)
        ENG_IDLE: begin
          if (calc_req) begin
            state <= ENG_LOAD;
            cnt   <= '0;
          end
        end
        ENG_LOAD: begin
          // Also leaves at once when K is zero
          if (cnt + 1'b1 >= k_len) begin
            state <= ENG_DRAIN;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ENG_DRAIN: begin
          if (cnt == `CFU_LANES) begin
            state <= ENG_WRITEBACK;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ENG_WRITEBACK: begin
          state    <= ENG_DONE;
          calc_ack <= 1'b1;
        end
        ENG_DONE: begin
          if (!calc_req) begin
            state    <= ENG_IDLE;
            calc_ack <= 1'b0;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // Read data is one cycle behind its address, zero bubbles otherwise
  assign row_valid = issue_q;
  assign row_a     = issue_q ? a_rdata : '0;
  assign row_b     = issue_q ? b_rdata : '0;

  assign eng_a = '{we: 1'b0, addr: cnt[`CFU_A_ADDR_BITS-1:0], data: '0};
  assign eng_b = '{we: 1'b0, addr: cnt[`CFU_B_ADDR_BITS-1:0], data: '0};
  assign eng_c = '{we: (state == ENG_WRITEBACK), addr: '0, data: acc_row};

  a_ack_in_done: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(calc_ack) |-> state == ENG_DONE
  );

endmodule

// ==== cfu_top.sv ====
`timescale 1ns/1ps
`include "cfu_defs.svh"

module cfu_top import cfu_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  input  logic [`CFU_FUNCT7_BITS+2:0] cmd_function_id,
  input  logic [31:0]                 cmd_inputs_0,
  input  logic [31:0]                 cmd_inputs_1,
  output logic                        rsp_valid,
  input  logic                        rsp_ready,
  output logic [31:0]                 rsp_output
);

  logic                                 calc_req;
  logic                                 calc_ack;
  logic                                 eng_grant;
  logic [`CFU_K_BITS-1:0]               k_len;
  logic                                 row_clear;
  logic                                 row_valid;
  elem_t                                row_a;
  logic [`CFU_LANES*`CFU_ELEM_BITS-1:0] row_b;
  row_t                                 acc_row;
  elem_t                                a_rdata;
  logic [`CFU_LANES*`CFU_ELEM_BITS-1:0] b_rdata;
  row_t                                 c_rdata;
  buf_a_req_t                           ctrl_a, eng_a, buf_a;
  buf_b_req_t                           ctrl_b, eng_b, buf_b;
  buf_c_req_t                           ctrl_c, eng_c, buf_c;

  cfu_cmd_ctrl i_cmd_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_output      (rsp_output),
    .calc_req        (calc_req),
    .calc_ack        (calc_ack),
    .k_len           (k_len),
    .eng_grant       (eng_grant),
    .ctrl_a          (ctrl_a),
    .ctrl_b          (ctrl_b),
    .ctrl_c          (ctrl_c),
    .c_rdata         (c_rdata)
  );

  matmul_engine i_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .calc_req  (calc_req),
    .k_len     (k_len),
    .calc_ack  (calc_ack),
    .row_clear (row_clear),
    .row_valid (row_valid),
    .row_a     (row_a),
    .row_b     (row_b),
    .a_rdata   (a_rdata),
    .b_rdata   (b_rdata),
    .acc_row   (acc_row),
    .eng_a     (eng_a),
    .eng_b     (eng_b),
    .eng_c     (eng_c)
  );

  systolic_row i_row (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (row_clear),
    .in_valid (row_valid),
    .a_in     (row_a),
    .b_in     (row_b),
    .acc_row  (acc_row)
  );

  buffer_arbiter i_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .eng_grant (eng_grant),
    .ctrl_a    (ctrl_a),
    .ctrl_b    (ctrl_b),
    .ctrl_c    (ctrl_c),
    .eng_a     (eng_a),
    .eng_b     (eng_b),
    .eng_c     (eng_c),
    .buf_a     (buf_a),
    .buf_b     (buf_b),
    .buf_c     (buf_c)
  );

  cfu_buffer #(
    .DATA_BITS (`CFU_ELEM_BITS),
    .ADDR_BITS (`CFU_A_ADDR_BITS)
  ) a_buf (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (buf_a.we),
    .addr  (buf_a.addr),
    .wdata (buf_a.data),
    .rdata (a_rdata)
  );

  cfu_buffer #(
    .DATA_BITS (`CFU_LANES*`CFU_ELEM_BITS),
    .ADDR_BITS (`CFU_B_ADDR_BITS)
  ) b_buf (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (buf_b.we),
    .addr  (buf_b.addr),
    .wdata (buf_b.data),
    .rdata (b_rdata)
  );

  cfu_buffer #(
    .DATA_BITS (`CFU_LANES*`CFU_ACC_BITS),
    .ADDR_BITS (`CFU_C_ADDR_BITS)
  ) c_buf (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (buf_c.we),
    .addr  (buf_c.addr),
    .wdata (buf_c.data),
    .rdata (c_rdata)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS   = 10,
  parameter int RESET_TICKS = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release reset just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_TICKS) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== tb_cfu.sv ====
`timescale 1ns/1ps
`include "cfu_defs.svh"

module tb_cfu import cfu_pkg::*; ();

  localparam int CMD_TIMEOUT = 1000;
  localparam int RSP_TIMEOUT = 1000;

  logic                        clk;
  logic                        rst_n;
  logic                        cmd_valid;
  logic                        cmd_ready;
  logic [`CFU_FUNCT7_BITS+2:0] cmd_function_id;
  logic [31:0]                 cmd_inputs_0;
  logic [31:0]                 cmd_inputs_1;
  logic                        rsp_valid;
  logic                        rsp_ready;
  logic [31:0]                 rsp_output;

  // Shadow copies of the three buffers
  elem_t       shadow_a [256];
  logic [31:0] shadow_b [256];
  acc_t        shadow_c [4][4];

  // Expected responses in command order
  // Kind 1 marks a C read
  bit          exp_kind [$];
  logic [31:0] exp_val [$];
  bit          rsp_kind;
  logic [31:0] rsp_exp;

  int errors;
  int checks;
  int tests_run;
  int test_err_start;

  tb_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cfu_top i_cfu_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_output      (rsp_output)
  );

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Errors found");
    $finish;
  endtask

  task automatic check_acc(input string name, input acc_t expv, input acc_t actv);
    checks++;
    if (actv !== expv) begin
      errors++;
      $display("** Error: %s expected %h, got %h", name, expv, actv);
    end
  endtask

  task automatic check_zero_rsp(input string name, input logic [31:0] actv);
    checks++;
    if (actv !== 32'h0) begin
      errors++;
      $display("** Error: %s expected %h, got %h", name, 32'h0, actv);
    end
  endtask

  task automatic check_flag(input string name, input logic expv, input logic actv);
    checks++;
    if (actv !== expv) begin
      errors++;
      $display("** Error: %s expected %h, got %h", name, expv, actv);
    end
  endtask

  // Sum over k of A[k] times signed byte col of B[k]
  function automatic acc_t ref_col(input int k_len, input int col);
    acc_t  sum;
    elem_t b_elem;
    sum = '0;
    for (int i = 0; i < k_len; i++) begin
      b_elem = shadow_b[i][31-8*col -: 8];
      sum = sum + int'(shadow_a[i]) * int'(b_elem);
    end
    return sum;
  endfunction

  // One expected entry is consumed per completed handshake
  always @(posedge clk) begin
    if (rst_n && rsp_valid && rsp_ready) begin
      if (exp_kind.size() == 0) begin
        errors++;
        $display("A response arrived with no command outstanding");
      end else begin
        rsp_kind = exp_kind.pop_front();
        rsp_exp  = exp_val.pop_front();
        if (rsp_kind) begin
          check_acc("rsp_output", acc_t'(rsp_exp), acc_t'(rsp_output));
        end else begin
          check_zero_rsp("rsp_output", rsp_output);
        end
      end
    end
  end

  // Called and returns 1 ns after a rising edge
  task automatic send_cmd(input logic [`CFU_FUNCT7_BITS-1:0] funct7,
                          input logic [31:0] in0, input logic [31:0] in1,
                          input bit is_read, input logic [31:0] expv);
    int waited;
    waited = 0;
    exp_kind.push_back(is_read);
    exp_val.push_back(expv);
    cmd_valid       = 1'b1;
    cmd_function_id = {funct7, 3'b000};
    cmd_inputs_0    = in0;
    cmd_inputs_1    = in1;
    do begin
      @(posedge clk);
      waited++;
      if (waited > CMD_TIMEOUT) abort_run("command was never accepted");
    end while (!cmd_ready);
    #1 cmd_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > RSP_TIMEOUT) abort_run("response never completed");
    end while (exp_kind.size() != 0);
    #1;
  endtask

  task automatic write_a(input logic [7:0] addr, input elem_t data);
    shadow_a[addr] = data;
    send_cmd(OP_WRITE_A, 32'(addr), {data, 24'($urandom)}, 1'b0, 32'h0);
  endtask

  task automatic write_b(input logic [7:0] addr, input logic [31:0] word);
    shadow_b[addr] = word;
    send_cmd(OP_WRITE_B, 32'(addr), word, 1'b0, 32'h0);
  endtask

  task automatic run_compute(input int k);
    send_cmd(OP_COMPUTE, 32'(k), 32'h0, 1'b0, 32'h0);
    for (int j = 0; j < `CFU_LANES; j++) begin
      shadow_c[0][j] = ref_col(k, j);
    end
    wait_idle();
  endtask

  task automatic read_c(input int row, input int col);
    send_cmd(OP_READ_C, 32'(row), 32'(col), 1'b1, shadow_c[row][col]);
  endtask

  task automatic read_row(input int row);
    for (int j = 0; j < `CFU_LANES; j++) begin
      read_c(row, j);
    end
    wait_idle();
  endtask

  task automatic fill_random(input int k);
    for (int i = 0; i < k; i++) begin
      write_a(8'(i), elem_t'($urandom));
      write_b(8'(i), $urandom);
    end
    wait_idle();
  endtask

  // Hold off the host side and watch the pending response
  task automatic hold_response(input int col);
    int   waited;
    int   hold_cycles;
    acc_t held;
    waited = 0;
    held = shadow_c[0][col];
    rsp_ready = 1'b0;
    read_c(0, col);
    do begin
      @(posedge clk);
      waited++;
      if (waited > RSP_TIMEOUT) abort_run("rsp_valid never rose");
    end while (!rsp_valid);
    hold_cycles = 3 + $urandom % 10;
    repeat (hold_cycles) begin
      @(posedge clk);
      check_flag("rsp_valid", 1'b1, rsp_valid);
      check_acc("rsp_output", held, acc_t'(rsp_output));
      check_flag("cmd_ready", 1'b0, cmd_ready);
    end
    #1 rsp_ready = 1'b1;
    wait_idle();
  endtask

  task automatic begin_test();
    tests_run++;
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_err_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               errors - test_err_start);
    end
  endtask

  initial begin : stimulus
    int waited;
    int k;
    elem_t a_val;
    void'($urandom(59));
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_inputs_0    = '0;
    cmd_inputs_1    = '0;
    rsp_ready       = 1'b1;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    for (int i = 0; i < 256; i++) begin
      shadow_a[i] = '0;
      shadow_b[i] = '0;
    end
    for (int r = 0; r < 4; r++) begin
      for (int j = 0; j < 4; j++) begin
        shadow_c[r][j] = '0;
      end
    end

    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 100) abort_run("reset never released");
    end while (!rst_n);
    #1;

    begin_test();
    for (int r = 0; r < 4; r++) begin
      read_row(r);
    end
    write_a(8'd0, 8'sd0);
    write_b(8'd0, 32'h0);
    wait_idle();
    end_test("reset_state");

    begin_test();
    repeat (3) begin
      k = 1 + $urandom % 16;
      fill_random(k);
      run_compute(k);
      read_row(0);
    end
    end_test("random_k");

    // Full depth with the signed extremes
    begin_test();
    for (int i = 0; i < 256; i++) begin
      a_val = (i % 4 == 3) ? elem_t'($urandom) : ((i % 2 == 1) ? 8'sd127 : -8'sd128);
      write_a(8'(i), a_val);
      write_b(8'(i), {8'h80, 8'h7f, (i % 3 == 0) ? 8'h80 : 8'h7f, 8'($urandom)});
    end
    wait_idle();
    run_compute(256);
    read_row(0);
    end_test("full_depth");

    begin_test();
    k = 1 + $urandom % 16;
    fill_random(k);
    run_compute(k);
    read_row(0);
    k = 1 + $urandom % 16;
    fill_random(k);
    run_compute(k);
    read_row(0);
    run_compute(0);
    read_row(0);
    end_test("back_to_back");

    begin_test();
    k = 1 + $urandom % 16;
    fill_random(k);
    run_compute(k);
    hold_response($urandom % 4);
    end_test("back_pressure");

    begin_test();
    send_cmd(7'(4 + $urandom % 124), $urandom, $urandom, 1'b0, 32'h0);
    wait_idle();
    read_row(0);
    end_test("unknown_op");

    $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
cfu_pkg.sv
cfu_buffer.sv
buffer_arbiter.sv
cfu_cmd_ctrl.sv
systolic_row.sv
matmul_engine.sv
cfu_top.sv
tb_clk_gen.sv
tb_cfu.sv
